// File: compile.f
verilog/scalar_fixed_pkg.sv
verilog/scalar_fixed_adder.sv
verilog/scalar_fixed_multiplier.sv
verilog/scalar_fixed_divider.sv
verilog/scalar_fixed_unit.sv
bench/scalar_fixed_clock.sv
bench/scalar_fixed_unit_tb.sv

// File: Bender.yml
package:
  name: scalar_fixed_unit

sources:
  # RTL in compile order
  - verilog/scalar_fixed_pkg.sv
  - verilog/scalar_fixed_adder.sv
  - verilog/scalar_fixed_multiplier.sv
  - verilog/scalar_fixed_divider.sv
  - verilog/scalar_fixed_unit.sv
  # Testbench
  - target: test
    files:
      - bench/scalar_fixed_clock.sv
      - bench/scalar_fixed_unit_tb.sv

// File: bench/scalar_fixed_unit_tb.sv
//////////////////////////////////////////////////
// Testbench for the scalar fixed-point unit
// Directed add, multiply, divide and busy tests,
// then random operations against a wide-integer
// reference model, with latency checks
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module scalar_fixed_unit_tb
  import scalar_fixed_pkg::*;
;

  localparam int FRAC_SIZE  = 16;
  localparam int PERIOD_NS  = 100;
  localparam int NUM_RANDOM = 200;
  // Directed plus random, with some slack
  localparam int NUM_OPS    = NUM_RANDOM + 40;
  localparam int OP_CYCLES  = DATA_SIZE + FRAC_SIZE + 3 + 4;
  localparam longint WATCHDOG_NS = longint'(NUM_OPS * OP_CYCLES + 50) * PERIOD_NS;

  localparam longint FRAC_ONE = longint'(1) << FRAC_SIZE;
  localparam longint MAX_VAL  = longint'($signed(FIXED_MAX));
  localparam longint MIN_VAL  = longint'($signed(FIXED_MIN));

  logic           CLK;
  logic           RST;
  logic           start;
  opcode_e        opcode;
  fixed_t         data_a;
  fixed_t         data_b;
  scalar_result_t result;
  logic           ready;
  logic           busy;
  logic [31:0]    rng;

  scalar_fixed_clock #(.PERIOD_NS(PERIOD_NS), .RESET_CYCLES(2)) clock0 (
    .CLK(CLK), .RST(RST)
  );

  scalar_fixed_unit #(.FRAC_SIZE(FRAC_SIZE)) dut0 (
    .CLK(CLK), .RST(RST), .START(start), .OPCODE(opcode), .DATA_A(data_a),
    .DATA_B(data_b), .RESULT(result), .READY(ready), .BUSY(busy)
  );

  //////////////////////////////////////////////////
  // Helpers

  task automatic check_value(input string name, input logic [63:0] want,
                             input logic [63:0] got);
    if (want !== got) begin
      $display("error %s: expected %0h, actual %0h", name, want, got);
      $display("Verification failed");
      $fatal(1);
    end
  endtask

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Random magnitude range via arithmetic shift
  task automatic random_operand(output fixed_t value);
    logic [31:0] raw;
    rng = xorshift(rng);
    raw = rng;
    rng = xorshift(rng);
    value = fixed_t'($signed(raw) >>> rng[4:0]);
  endtask

  // Drive edge to READY seen, result register included
  function automatic int expected_latency(input opcode_e op);
    case (op)
      OP_MUL:  return DATA_SIZE + 2 + 1;
      OP_DIV:  return DATA_SIZE + FRAC_SIZE + 2 + 1;
      default: return 1 + 1;
    endcase
  endfunction

  // Exact arithmetic, truncation toward zero, then clamp
  task automatic model_result(input opcode_e op, input fixed_t a, input fixed_t b,
                              output scalar_result_t want);
    longint sa;
    longint sb;
    longint full;
    sa = longint'($signed(a));
    sb = longint'($signed(b));
    case (op)
      OP_ADD:  full = sa + sb;
      OP_SUB:  full = sa - sb;
      OP_MUL:  full = (sa * sb) / FRAC_ONE;
      default: full = (sb == 0) ? 0 : (sa * FRAC_ONE) / sb;
    endcase
    want.overflow = 1'b1;
    if (op == OP_DIV && sb == 0) begin
      want.data = (sa < 0) ? FIXED_MIN : FIXED_MAX;
    end else if (full > MAX_VAL) begin
      want.data = FIXED_MAX;
    end else if (full < MIN_VAL) begin
      want.data = FIXED_MIN;
    end else begin
      want.overflow = 1'b0;
      want.data     = fixed_t'(full);
    end
  endtask

  task automatic launch_op(input opcode_e op, input fixed_t a, input fixed_t b);
    @(posedge CLK);
    start  <= 1'b1;
    opcode <= op;
    data_a <= a;
    data_b <= b;
  endtask

  // Count edges until READY, sampled mid-cycle
  task automatic wait_ready(inout int cycles);
    do begin
      @(posedge CLK);
      start <= 1'b0;
      cycles++;
      @(negedge CLK);
    end while (!ready);
  endtask

  task automatic run_op(input string name, input opcode_e op, input fixed_t a,
                        input fixed_t b);
    scalar_result_t want;
    int             cycles;
    cycles = 0;
    model_result(op, a, b, want);
    launch_op(op, a, b);
    wait_ready(cycles);
    check_value({name, " latency"}, expected_latency(op), cycles);
    check_value({name, " data"}, want.data, result.data);
    check_value({name, " overflow"}, want.overflow, result.overflow);
    check_value({name, " busy"}, 1, busy);
  endtask

  //////////////////////////////////////////////////
  // Tests

  task automatic reset_test();
    @(negedge RST);
    @(negedge CLK);
    check_value("reset ready", 0, ready);
    check_value("reset busy", 0, busy);
    check_value("reset result", 0, result);
  endtask

  task automatic add_tests();
    run_op("add small", OP_ADD, 32'h0001_8000, 32'h0002_4000);
    run_op("add negative", OP_ADD, 32'hfffe_8000, 32'h0000_4000);
    run_op("sub small", OP_SUB, 32'h0001_0000, 32'h0003_0000);
    run_op("add pos overflow", OP_ADD, FIXED_MAX, 32'h0000_0001);
    run_op("add neg overflow", OP_ADD, FIXED_MIN, 32'hffff_ffff);
    run_op("sub pos overflow", OP_SUB, FIXED_MAX, 32'hffff_0000);
    run_op("sub neg overflow", OP_SUB, FIXED_MIN, 32'h0000_0001);
  endtask

  task automatic mul_tests();
    run_op("mul pos pos", OP_MUL, 32'h0001_8000, 32'h0002_0000);
    run_op("mul neg pos", OP_MUL, 32'hfffe_8000, 32'h0002_0000);
    run_op("mul pos neg", OP_MUL, 32'h0001_8000, 32'hffff_4000);
    run_op("mul neg neg", OP_MUL, 32'hffff_8000, 32'hffff_8000);
    // Half an LSB lost either side of zero
    run_op("mul trunc pos", OP_MUL, 32'h0000_0003, 32'h0000_8000);
    run_op("mul trunc neg", OP_MUL, 32'hffff_fffd, 32'h0000_8000);
    run_op("mul pos overflow", OP_MUL, 32'h4000_0000, 32'h0004_0000);
    run_op("mul neg overflow", OP_MUL, 32'hc000_0000, 32'h0004_0000);
    run_op("mul min by one", OP_MUL, FIXED_MIN, 32'h0001_0000);
  endtask

  task automatic div_tests();
    run_op("div exact", OP_DIV, 32'h0006_0000, 32'h0002_0000);
    run_op("div third", OP_DIV, 32'h0001_0000, 32'h0003_0000);
    run_op("div neg third", OP_DIV, 32'hffff_0000, 32'h0003_0000);
    run_op("div neg divisor", OP_DIV, 32'h0007_0000, 32'hfffe_0000);
    run_op("div pos overflow", OP_DIV, 32'h4000_0000, 32'h0000_0100);
    run_op("div neg overflow", OP_DIV, 32'h4000_0000, 32'hffff_ff00);
    run_op("div zero pos", OP_DIV, 32'h0001_0000, 32'h0000_0000);
    run_op("div zero neg", OP_DIV, 32'hffff_0000, 32'h0000_0000);
    run_op("div min by minus one", OP_DIV, FIXED_MIN, 32'hffff_0000);
  endtask

  // Second START lands mid-divide and must vanish
  task automatic busy_test();
    scalar_result_t want;
    int             cycles;
    cycles = 0;
    model_result(OP_DIV, 32'h0005_0000, 32'h0002_0000, want);
    launch_op(OP_DIV, 32'h0005_0000, 32'h0002_0000);
    @(posedge CLK);
    start <= 1'b0;
    @(posedge CLK);
    cycles = 2;
    @(negedge CLK);
    check_value("busy during divide", 1, busy);
    @(posedge CLK);
    start  <= 1'b1;
    opcode <= OP_ADD;
    data_a <= 32'h0001_0000;
    data_b <= 32'h0001_0000;
    cycles++;
    wait_ready(cycles);
    check_value("busy ignore latency", expected_latency(OP_DIV), cycles);
    check_value("busy ignore data", want.data, result.data);
    check_value("busy ignore overflow", want.overflow, result.overflow);
    @(negedge CLK);
    check_value("busy release", 0, busy);
    // No late READY from the dropped add
    repeat (4) begin
      check_value("busy extra ready", 0, ready);
      @(negedge CLK);
    end
  endtask

  task automatic random_tests();
    fixed_t  a;
    fixed_t  b;
    opcode_e op;
    for (int i = 0; i < NUM_RANDOM; i++) begin
      rng = xorshift(rng);
      op  = opcode_e'(rng[1:0]);
      random_operand(a);
      random_operand(b);
      run_op($sformatf("random %0d", i), op, a, b);
    end
  endtask

  //////////////////////////////////////////////////
  // Main sequence and watchdog

  initial begin
    start  = 1'b0;
    opcode = OP_ADD;
    data_a = '0;
    data_b = '0;
    rng    = 32'h3db1_705e;
    reset_test();
    add_tests();
    mul_tests();
    div_tests();
    busy_test();
    random_tests();
    $display("Verification passed");
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("timeout: the DUT did not finish all operations in the expected time");
    $display("Verification failed");
    $fatal(1);
  end

endmodule

`default_nettype wire

// File: bench/scalar_fixed_clock.sv
//////////////////////////////////////////////////
// Testbench clock and reset generator
// Free-running clock, reset held a few cycles
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module scalar_fixed_clock #(
  parameter int PERIOD_NS    = 100,
  parameter int RESET_CYCLES = 2
) (
  output logic CLK,
  output logic RST
);

  initial begin
    CLK = 1'b0;
    forever #(PERIOD_NS / 2) CLK = ~CLK;
  end

  // Release reset on a rising edge
  initial begin
    RST = 1'b1;
    repeat (RESET_CYCLES) @(posedge CLK);
    RST <= 1'b0;
  end

endmodule

`default_nettype wire

// File: verilog/scalar_fixed_unit.sv
//////////////////////////////////////////////////
// Scalar fixed-point arithmetic unit
// Dispatches one operation at a time to the adder,
// multiplier or divider and registers its result
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module scalar_fixed_unit
  import scalar_fixed_pkg::*;
#(
  parameter int FRAC_SIZE = 16
) (
  input  wire            CLK,
  input  wire            RST,
  input  wire            START,
  input  wire opcode_e   OPCODE,
  input  wire fixed_t    DATA_A,
  input  wire fixed_t    DATA_B,
  output scalar_result_t RESULT,
  output logic           READY,
  output logic           BUSY
);

  logic           accept;
  logic           add_start;
  logic           mul_start;
  logic           div_start;
  logic           subtract;
  scalar_result_t add_result;
  scalar_result_t mul_result;
  scalar_result_t div_result;
  logic           add_ready;
  logic           mul_ready;
  logic           div_ready;

  //////////////////////////////////////////////////
  // Dispatch

  // START while busy is dropped
  assign accept    = START & ~BUSY;
  assign subtract  = (OPCODE == OP_SUB);
  assign add_start = accept & ((OPCODE == OP_ADD) | subtract);
  assign mul_start = accept & (OPCODE == OP_MUL);
  assign div_start = accept & (OPCODE == OP_DIV);

  scalar_fixed_adder adder0 (
    .CLK(CLK), .RST(RST), .START(add_start), .SUBTRACT(subtract),
    .DATA_A(DATA_A), .DATA_B(DATA_B), .RESULT(add_result), .READY(add_ready)
  );

  scalar_fixed_multiplier #(.FRAC_SIZE(FRAC_SIZE)) multiplier0 (
    .CLK(CLK), .RST(RST), .START(mul_start),
    .DATA_A(DATA_A), .DATA_B(DATA_B), .RESULT(mul_result), .READY(mul_ready)
  );

  scalar_fixed_divider #(.FRAC_SIZE(FRAC_SIZE)) divider0 (
    .CLK(CLK), .RST(RST), .START(div_start),
    .DATA_A(DATA_A), .DATA_B(DATA_B), .RESULT(div_result), .READY(div_ready)
  );

  //////////////////////////////////////////////////
  // Result register and busy

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      RESULT <= '0;
      READY  <= 1'b0;
      BUSY   <= 1'b0;
    end else begin
      READY <= add_ready | mul_ready | div_ready;
      // Only one unit in flight, so at most one ready
      if (add_ready) begin
        RESULT <= add_result;
      end else if (mul_ready) begin
        RESULT <= mul_result;
      end else if (div_ready) begin
        RESULT <= div_result;
      end
      // Busy covers the READY cycle itself
      if (READY) begin
        BUSY <= 1'b0;
      end else if (accept) begin
        BUSY <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: verilog/scalar_fixed_divider.sv
//////////////////////////////////////////////////
// Scalar fixed-point divider
// Bit-serial restoring division of magnitudes,
// dividend prescaled by the fraction width, with
// divide-by-zero and range saturation
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module scalar_fixed_divider
  import scalar_fixed_pkg::*;
#(
  parameter int FRAC_SIZE = 16
) (
  input  wire            CLK,
  input  wire            RST,
  input  wire            START,
  input  wire fixed_t    DATA_A,
  input  wire fixed_t    DATA_B,
  output scalar_result_t RESULT,
  output logic           READY
);

  // Quotient bits produced, one per cycle
  localparam int STEPS = DATA_SIZE + FRAC_SIZE;
  localparam int CNT_W = $clog2(STEPS);

  div_state_e           state;
  logic [CNT_W-1:0]     count;
  logic                 neg;
  logic                 a_neg;
  logic                 div_zero;
  fixed_t               divisor;
  fixed_t               rem;
  logic [STEPS-1:0]     quo;
  logic [DATA_SIZE:0]   trial;
  logic [DATA_SIZE+1:0] diff;
  logic                 fits;
  fixed_t               mag_a;
  fixed_t               mag_b;
  fixed_t               mag_q;
  logic                 too_big;

  assign mag_a = DATA_A[DATA_SIZE-1] ? -DATA_A : DATA_A;
  assign mag_b = DATA_B[DATA_SIZE-1] ? -DATA_B : DATA_B;

  //////////////////////////////////////////////////
  // Restoring step

  // Bring down next dividend bit
  assign trial = {rem, quo[STEPS-1]};
  // Trial subtract, borrow in the top bit
  assign diff  = {1'b0, trial} - {2'b00, divisor};
  assign fits  = ~diff[DATA_SIZE+1];

  // Range limits, negative one step wider
  assign too_big = neg ? (quo > STEPS'(FIXED_MIN)) : (quo > STEPS'(FIXED_MAX));
  assign mag_q   = quo[DATA_SIZE-1:0];

  //////////////////////////////////////////////////
  // Control FSM

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state <= DIV_IDLE;
      count <= '0;
      READY <= 1'b0;
    end else begin
      READY <= 1'b0;
      case (state)
        DIV_IDLE: begin
          if (START) begin
            state <= DIV_RUN;
            count <= '0;
          end
        end
        DIV_RUN: begin
          count <= count + 1'b1;
          if (count == CNT_W'(STEPS - 1)) begin
            state <= DIV_FINISH;
          end
        end
        DIV_FINISH: begin
          READY <= 1'b1;
          state <= DIV_IDLE;
        end
        default: state <= DIV_IDLE;
      endcase
    end
  end

  //////////////////////////////////////////////////
  // Datapath

  always_ff @(posedge CLK) begin
    case (state)
      DIV_IDLE: begin
        if (START) begin
          neg      <= DATA_A[DATA_SIZE-1] ^ DATA_B[DATA_SIZE-1];
          a_neg    <= DATA_A[DATA_SIZE-1];
          div_zero <= (DATA_B == '0);
          divisor  <= mag_b;
          rem      <= '0;
          // Prescale so the quotient keeps FRAC_SIZE fraction bits
          quo      <= STEPS'(mag_a) << FRAC_SIZE;
        end
      end
      DIV_RUN: begin
        // Keep difference or restore, quotient bit shifts in
        rem <= fits ? diff[DATA_SIZE-1:0] : trial[DATA_SIZE-1:0];
        quo <= {quo[STEPS-2:0], fits};
      end
      DIV_FINISH: begin
        if (div_zero) begin
          // Saturate by dividend sign
          RESULT.overflow <= 1'b1;
          RESULT.data     <= a_neg ? FIXED_MIN : FIXED_MAX;
        end else if (too_big) begin
          RESULT.overflow <= 1'b1;
          RESULT.data     <= neg ? FIXED_MIN : FIXED_MAX;
        end else begin
          // Truncated toward zero
          RESULT.overflow <= 1'b0;
          RESULT.data     <= neg ? -mag_q : mag_q;
        end
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

// File: verilog/scalar_fixed_multiplier.sv
//////////////////////////////////////////////////
// Scalar fixed-point multiplier
// Sequential shift-add on operand magnitudes,
// one partial product per cycle, then scaling by
// the fraction width and saturation
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module scalar_fixed_multiplier
  import scalar_fixed_pkg::*;
#(
  parameter int FRAC_SIZE = 16
) (
  input  wire            CLK,
  input  wire            RST,
  input  wire            START,
  input  wire fixed_t    DATA_A,
  input  wire fixed_t    DATA_B,
  output scalar_result_t RESULT,
  output logic           READY
);

  localparam int CNT_W = $clog2(DATA_SIZE);

  mul_state_e             state;
  logic [CNT_W-1:0]       count;
  logic                   neg;
  logic [2*DATA_SIZE-1:0] mcand;
  fixed_t                 mplier;
  logic [2*DATA_SIZE-1:0] product;
  logic [2*DATA_SIZE-1:0] scaled;
  fixed_t                 mag_a;
  fixed_t                 mag_b;
  fixed_t                 mag_q;
  logic                   too_big;

  // Operand magnitudes, MIN maps to 2^31 unsigned
  assign mag_a = DATA_A[DATA_SIZE-1] ? -DATA_A : DATA_A;
  assign mag_b = DATA_B[DATA_SIZE-1] ? -DATA_B : DATA_B;

  // Drop fraction bits, magnitude truncation
  assign scaled = product >> FRAC_SIZE;
  assign mag_q  = scaled[DATA_SIZE-1:0];

  // Negative side reaches one further than positive
  assign too_big = neg ? (scaled > (2*DATA_SIZE)'(FIXED_MIN)) :
                         (scaled > (2*DATA_SIZE)'(FIXED_MAX));

  //////////////////////////////////////////////////
  // Control FSM

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state <= MUL_IDLE;
      count <= '0;
      READY <= 1'b0;
    end else begin
      READY <= 1'b0;
      case (state)
        MUL_IDLE: begin
          if (START) begin
            state <= MUL_RUN;
            count <= '0;
          end
        end
        MUL_RUN: begin
          // One multiplier bit per cycle
          count <= count + 1'b1;
          if (count == CNT_W'(DATA_SIZE - 1)) begin
            state <= MUL_FINISH;
          end
        end
        MUL_FINISH: begin
          READY <= 1'b1;
          state <= MUL_IDLE;
        end
        default: state <= MUL_IDLE;
      endcase
    end
  end

  //////////////////////////////////////////////////
  // Datapath

  always_ff @(posedge CLK) begin
    case (state)
      MUL_IDLE: begin
        if (START) begin
          neg     <= DATA_A[DATA_SIZE-1] ^ DATA_B[DATA_SIZE-1];
          mcand   <= (2*DATA_SIZE)'(mag_a);
          mplier  <= mag_b;
          product <= '0;
        end
      end
      MUL_RUN: begin
        // Add shifted multiplicand when bit is set
        if (mplier[0]) begin
          product <= product + mcand;
        end
        mcand  <= mcand << 1;
        mplier <= mplier >> 1;
      end
      MUL_FINISH: begin
        RESULT.overflow <= too_big;
        if (too_big) begin
          RESULT.data <= neg ? FIXED_MIN : FIXED_MAX;
        end else begin
          RESULT.data <= neg ? -mag_q : mag_q;
        end
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

// File: verilog/scalar_fixed_adder.sv
//////////////////////////////////////////////////
// Scalar fixed-point adder
// One-cycle saturating add or subtract of two
// signed words, with overflow flag
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module scalar_fixed_adder
  import scalar_fixed_pkg::*;
(
  input  wire            CLK,
  input  wire            RST,
  input  wire            START,
  input  wire            SUBTRACT,
  input  wire fixed_t    DATA_A,
  input  wire fixed_t    DATA_B,
  output scalar_result_t RESULT,
  output logic           READY
);

  //////////////////////////////////////////////////
  // Wide sum

  // One guard bit above the word
  logic [DATA_SIZE:0] wide_a;
  logic [DATA_SIZE:0] wide_b;
  logic [DATA_SIZE:0] wide_sum;
  logic               ovf;

  // Sign extend both operands
  assign wide_a = {DATA_A[DATA_SIZE-1], DATA_A};
  assign wide_b = {DATA_B[DATA_SIZE-1], DATA_B};

  assign wide_sum = SUBTRACT ? (wide_a - wide_b) : (wide_a + wide_b);

  // Guard and sign bit disagree on overflow
  assign ovf = wide_sum[DATA_SIZE] ^ wide_sum[DATA_SIZE-1];

  //////////////////////////////////////////////////
  // Output register

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      READY  <= 1'b0;
      RESULT <= '0;
    end else begin
      // Single pulse per START
      READY <= START;
      if (START) begin
        RESULT.overflow <= ovf;
        // Saturate by sign of the true result
        if (ovf) begin
          RESULT.data <= wide_sum[DATA_SIZE] ? FIXED_MIN : FIXED_MAX;
        end else begin
          RESULT.data <= wide_sum[DATA_SIZE-1:0];
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: verilog/scalar_fixed_pkg.sv
//////////////////////////////////////////////////
// Scalar fixed-point arithmetic package
// Word width, operand and opcode types, result
// struct, saturation limits and FSM states shared
// by the adder, multiplier, divider and top level
//////////////////////////////////////////////////

`default_nettype none

package scalar_fixed_pkg;

  // Word width of every operand and result
  localparam int DATA_SIZE = 32;

  // One signed two's-complement fixed-point value
  typedef logic [DATA_SIZE-1:0] fixed_t;

  // Saturation limits
  localparam fixed_t FIXED_MAX = {1'b0, {(DATA_SIZE-1){1'b1}}};
  localparam fixed_t FIXED_MIN = {1'b1, {(DATA_SIZE-1){1'b0}}};

  // Operation select
  typedef enum logic [1:0] {OP_ADD, OP_SUB, OP_MUL, OP_DIV} opcode_e;

  // Result word with its overflow flag
  typedef struct packed {
    fixed_t data;
    logic   overflow;
  } scalar_result_t;

  // Sequential unit states
  typedef enum logic [1:0] {MUL_IDLE, MUL_RUN, MUL_FINISH} mul_state_e;
  typedef enum logic [1:0] {DIV_IDLE, DIV_RUN, DIV_FINISH} div_state_e;

endpackage

`default_nettype wire
